/* design/fade_stripe_pkg.sv */
`default_nettype none

package fade_stripe_pkg;

  localparam int ADC_DATA_BITS = 10;
  localparam int PIXEL_BITS    = 9;
  localparam int COLOR_BITS    = PIXEL_BITS / 3;
  localparam int FB_INDEX_BITS = 18;
  localparam int COORD_BITS    = 12;
  localparam int APB_ADDR_BITS = 8;
  localparam int APB_DATA_BITS = 32;
  localparam int FRAME_CNT_BITS = 16;

  typedef logic [ADC_DATA_BITS-1:0]  adc_t;
  typedef logic [COLOR_BITS-1:0]     color_t;
  // red high, green middle, blue low
  typedef logic [PIXEL_BITS-1:0]     pixel_t;
  typedef logic [FB_INDEX_BITS-1:0]  fb_index_t;
  typedef logic [COORD_BITS-1:0]     coord_t;
  typedef logic [APB_ADDR_BITS-1:0]  apb_addr_t;
  typedef logic [APB_DATA_BITS-1:0]  apb_data_t;
  typedef logic [FRAME_CNT_BITS-1:0] frame_cnt_t;

  typedef struct packed {
    adc_t x;
    adc_t y;
    logic red;
    logic grn;
    logic blu;
  } adc_sample_t;

  typedef struct packed {
    logic      en;
    fb_index_t index;
    pixel_t    data;
  } fb_wr_t;

  typedef struct packed {
    logic      en;
    fb_index_t index;
  } fb_rd_t;

  typedef struct packed {
    color_t red;
    color_t grn;
    color_t blu;
    logic   hsync;
    logic   vsync;
  } vga_t;

  // syncs are carried active low
  typedef struct packed {
    logic   visible;
    coord_t x;
    coord_t y;
    logic   frame_start;
    logic   hsync;
    logic   vsync;
  } scan_pos_t;

  localparam apb_addr_t REG_CTRL        = 8'h0;
  localparam apb_addr_t REG_FADE_PERIOD = 8'h4;
  localparam apb_addr_t REG_FRAME_COUNT = 8'h8;

  localparam int CTRL_PLOT_EN = 0;
  localparam int CTRL_FADE_EN = 1;

endpackage

`default_nettype wire

/* design/vga_timing.sv */
`timescale 1ns/10ps
`default_nettype none

module vga_timing
  import fade_stripe_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic      clk,
    input  logic      rst,
    output scan_pos_t scan,
    output logic      frame_start
);
  localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

  coord_t h_next;
  coord_t v_next;

  function automatic scan_pos_t pos(coord_t h, coord_t v);
    scan_pos_t p;
    p.visible     = (int'(h) < H_ACTIVE) && (int'(v) < V_ACTIVE);
    p.x           = h;
    p.y           = v;
    p.frame_start = (h == '0) && (v == '0);
    p.hsync       = !((int'(h) >= H_SYNC_START) && (int'(h) < H_SYNC_START + H_SYNC));
    p.vsync       = !((int'(v) >= V_SYNC_START) && (int'(v) < V_SYNC_START + V_SYNC));
    return p;
  endfunction

  // scan.x and scan.y are the counters themselves
  always_comb begin
    h_next = scan.x + 1'b1;
    v_next = scan.y;
    if (int'(scan.x) == H_TOTAL - 1) begin
      h_next = '0;
      v_next = (int'(scan.y) == V_TOTAL - 1) ? '0 : scan.y + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      scan <= pos('0, '0);
    end else begin
      scan <= pos(h_next, v_next);
    end
  end

  assign frame_start = scan.frame_start;

endmodule

`default_nettype wire

/* design/adc_plot.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_plot
  import fade_stripe_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 480
) (
    input  logic        clk,
    input  logic        rst,
    input  adc_sample_t sample,
    input  logic        adc_valid,
    input  logic        plot_en,
    output fb_wr_t      plot_wr
);
  localparam int X_SHIFT = ADC_DATA_BITS - $clog2(H_ACTIVE);
  localparam int Y_SHIFT = ADC_DATA_BITS - $clog2(V_ACTIVE);

  adc_t      x_scaled;
  adc_t      y_scaled;
  logic      in_range;
  logic      wr_en;
  fb_index_t wr_index;
  pixel_t    wr_data;

  always_comb begin
    x_scaled = sample.x >> X_SHIFT;
    y_scaled = sample.y >> Y_SHIFT;
    // full scale can land past the active area
    in_range = (int'(x_scaled) < H_ACTIVE) && (int'(y_scaled) < V_ACTIVE);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= adc_valid && plot_en && in_range;
    end
  end

  always_ff @(posedge clk) begin
    wr_index <= fb_index_t'(y_scaled) * fb_index_t'(H_ACTIVE) + fb_index_t'(x_scaled);
    wr_data  <= {{COLOR_BITS{sample.red}}, {COLOR_BITS{sample.grn}}, {COLOR_BITS{sample.blu}}};
  end

  assign plot_wr = '{en: wr_en, index: wr_index, data: wr_data};

endmodule

`default_nettype wire

/* design/stripe_framebuffer.sv */
`timescale 1ns/10ps
`default_nettype none

module stripe_framebuffer
  import fade_stripe_pkg::*;
#(
    parameter int NUM_S      = 4,
    parameter int BANK_DEPTH = 19200
) (
    input  logic   clk,
    input  logic   rst,
    input  fb_wr_t plot_wr,
    input  fb_wr_t fade_wr,
    input  fb_rd_t rd,
    output pixel_t rd_data
);
  localparam int BANK_BITS = $clog2(NUM_S);
  localparam int ADDR_BITS = $clog2(BANK_DEPTH);

  logic [BANK_BITS-1:0] plot_bank;
  logic [BANK_BITS-1:0] fade_bank;
  logic [BANK_BITS-1:0] rd_bank;
  logic [BANK_BITS-1:0] rd_bank_q;
  logic [ADDR_BITS-1:0] plot_addr;
  logic [ADDR_BITS-1:0] fade_addr;
  logic [ADDR_BITS-1:0] rd_addr;

  logic                 clearing;
  logic [ADDR_BITS-1:0] sweep_addr;

  logic [NUM_S-1:0]     bank_we;
  logic [ADDR_BITS-1:0] bank_waddr [NUM_S];
  pixel_t               bank_wdata [NUM_S];
  pixel_t               bank_q     [NUM_S];

  // low index bits pick the bank, the rest address within it
  assign plot_bank = plot_wr.index[BANK_BITS-1:0];
  assign fade_bank = fade_wr.index[BANK_BITS-1:0];
  assign rd_bank   = rd.index[BANK_BITS-1:0];
  assign plot_addr = plot_wr.index[BANK_BITS +: ADDR_BITS];
  assign fade_addr = fade_wr.index[BANK_BITS +: ADDR_BITS];
  assign rd_addr   = rd.index[BANK_BITS +: ADDR_BITS];

  always_ff @(posedge clk) begin
    if (rst) begin
      clearing   <= 1'b1;
      sweep_addr <= '0;
    end else if (clearing) begin
      sweep_addr <= sweep_addr + 1'b1;
      if (sweep_addr == ADDR_BITS'(BANK_DEPTH - 1)) begin
        clearing <= 1'b0;
      end
    end
  end

  // plot beats fade on a shared bank
  always_comb begin
    for (int b = 0; b < NUM_S; b++) begin
      bank_we[b]    = 1'b0;
      bank_waddr[b] = fade_addr;
      bank_wdata[b] = fade_wr.data;
      if (clearing) begin
        bank_we[b]    = 1'b1;
        bank_waddr[b] = sweep_addr;
        bank_wdata[b] = '0;
      end else if (plot_wr.en && (int'(plot_bank) == b)) begin
        bank_we[b]    = 1'b1;
        bank_waddr[b] = plot_addr;
        bank_wdata[b] = plot_wr.data;
      end else if (fade_wr.en && (int'(fade_bank) == b)) begin
        bank_we[b] = 1'b1;
      end
    end
  end

  for (genvar b = 0; b < NUM_S; b++) begin : g_bank
    pixel_t mem [BANK_DEPTH];

    always_ff @(posedge clk) begin
      if (bank_we[b]) begin
        mem[bank_waddr[b]] <= bank_wdata[b];
      end
      if (rd.en) begin
        bank_q[b] <= mem[rd_addr];
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_bank_q <= rd_bank;
  end

  assign rd_data = bank_q[rd_bank_q];

endmodule

`default_nettype wire

/* design/fade_scanout.sv */
`timescale 1ns/10ps
`default_nettype none

module fade_scanout
  import fade_stripe_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 480
) (
    input  logic      clk,
    input  logic      rst,
    input  scan_pos_t scan,
    input  logic      fade_now,
    output fb_rd_t    rd,
    input  pixel_t    rd_data,
    output fb_wr_t    fade_wr,
    output vga_t      vga
);
  localparam int LAST_INDEX = H_ACTIVE * V_ACTIVE - 1;

  fb_index_t rd_index;
  logic      fade_frame;

  logic      s1_visible;
  logic      s1_hsync;
  logic      s1_vsync;
  fb_index_t s1_index;

  logic      s2_visible;
  logic      s2_hsync;
  logic      s2_vsync;
  fb_index_t s2_index;
  pixel_t    s2_pix;
  pixel_t    shown;

  // one step dimmer per channel, floor at 0
  function automatic pixel_t dim(pixel_t p);
    pixel_t q;
    for (int c = 0; c < 3; c++) begin
      color_t ch;
      ch = p[c*COLOR_BITS +: COLOR_BITS];
      q[c*COLOR_BITS +: COLOR_BITS] = (ch == '0) ? '0 : ch - color_t'(1);
    end
    return q;
  endfunction

  assign rd_index = fb_index_t'(scan.y) * fb_index_t'(H_ACTIVE) + fb_index_t'(scan.x);
  assign rd       = '{en: scan.visible, index: rd_index};

  always_ff @(posedge clk) begin
    if (rst) begin
      fade_frame <= 1'b0;
    end else if (scan.frame_start) begin
      fade_frame <= fade_now;
    end else if (s2_visible && (s2_index == fb_index_t'(LAST_INDEX))) begin
      fade_frame <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_visible <= 1'b0;
      s1_hsync   <= 1'b1;
      s1_vsync   <= 1'b1;
      s2_visible <= 1'b0;
      s2_hsync   <= 1'b1;
      s2_vsync   <= 1'b1;
    end else begin
      s1_visible <= scan.visible;
      s1_hsync   <= scan.hsync;
      s1_vsync   <= scan.vsync;
      s2_visible <= s1_visible;
      s2_hsync   <= s1_hsync;
      s2_vsync   <= s1_vsync;
    end
  end

  // bank data lands in stage 1
  always_ff @(posedge clk) begin
    s1_index <= rd_index;
    s2_index <= s1_index;
    s2_pix   <= rd_data;
  end

  assign shown = s2_visible ? s2_pix : '0;

  assign vga = '{
      red: shown[2*COLOR_BITS +: COLOR_BITS],
      grn: shown[COLOR_BITS +: COLOR_BITS],
      blu: shown[0 +: COLOR_BITS],
      hsync: s2_hsync,
      vsync: s2_vsync
  };

  assign fade_wr = '{en: fade_frame && s2_visible, index: s2_index, data: dim(s2_pix)};

endmodule

`default_nettype wire

/* design/apb_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_ctrl
  import fade_stripe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    input  logic      frame_start,
    output logic      plot_en,
    output logic      fade_now
);
  logic       fade_en;
  frame_cnt_t fade_period;
  frame_cnt_t fade_div;
  frame_cnt_t frame_count;

  logic       setup;
  logic       access;
  logic       addr_ok;
  apb_data_t  rd_val;

  always_comb begin
    setup   = psel && !penable;
    access  = psel && penable;
    addr_ok = 1'b1;
    rd_val  = '0;
    case (paddr)
      REG_CTRL: begin
        rd_val[CTRL_PLOT_EN] = plot_en;
        rd_val[CTRL_FADE_EN] = fade_en;
      end
      REG_FADE_PERIOD: rd_val = apb_data_t'(fade_period);
      REG_FRAME_COUNT: rd_val = apb_data_t'(frame_count);
      default: addr_ok = 1'b0;
    endcase
  end

  // response is set up a cycle early so it sits on the bus in the access cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end else begin
      prdata  <= (setup && !pwrite) ? rd_val : '0;
      pslverr <= setup && !addr_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      plot_en     <= 1'b0;
      fade_en     <= 1'b0;
      fade_period <= '0;
    end else if (access && pwrite) begin
      if (paddr == REG_CTRL) begin
        plot_en <= pwdata[CTRL_PLOT_EN];
        fade_en <= pwdata[CTRL_FADE_EN];
      end
      if (paddr == REG_FADE_PERIOD) begin
        fade_period <= frame_cnt_t'(pwdata);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fade_div    <= '0;
      frame_count <= '0;
    end else if (frame_start) begin
      frame_count <= frame_count + 1'b1;
      fade_div    <= (fade_div >= fade_period) ? '0 : fade_div + 1'b1;
    end
  end

  assign fade_now = fade_en && (fade_div >= fade_period);
  assign pready   = 1'b1;

endmodule

`default_nettype wire

/* design/adc_xy_vga_fade_stripe.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_xy_vga_fade_stripe
  import fade_stripe_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33,
    parameter int NUM_S    = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  adc_sample_t sample,
    input  logic        adc_valid,
    input  apb_addr_t   paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_data_t   pwdata,
    output apb_data_t   prdata,
    output logic        pready,
    output logic        pslverr,
    output vga_t        vga
);
  // each bank holds every NUM_S-th pixel of the active area
  localparam int BANK_DEPTH = (H_ACTIVE * V_ACTIVE + NUM_S - 1) / NUM_S;

  scan_pos_t scan;
  logic      frame_start;
  logic      plot_en;
  logic      fade_now;
  fb_wr_t    plot_wr;
  fb_wr_t    fade_wr;
  fb_rd_t    rd;
  pixel_t    rd_data;

  vga_timing #(
      .H_ACTIVE(H_ACTIVE),
      .H_FRONT (H_FRONT),
      .H_SYNC  (H_SYNC),
      .H_BACK  (H_BACK),
      .V_ACTIVE(V_ACTIVE),
      .V_FRONT (V_FRONT),
      .V_SYNC  (V_SYNC),
      .V_BACK  (V_BACK)
  ) i_vga_timing (
      .clk        (clk),
      .rst        (rst),
      .scan       (scan),
      .frame_start(frame_start)
  );

  adc_plot #(
      .H_ACTIVE(H_ACTIVE),
      .V_ACTIVE(V_ACTIVE)
  ) i_adc_plot (
      .clk      (clk),
      .rst      (rst),
      .sample   (sample),
      .adc_valid(adc_valid),
      .plot_en  (plot_en),
      .plot_wr  (plot_wr)
  );

  stripe_framebuffer #(
      .NUM_S     (NUM_S),
      .BANK_DEPTH(BANK_DEPTH)
  ) i_stripe_framebuffer (
      .clk    (clk),
      .rst    (rst),
      .plot_wr(plot_wr),
      .fade_wr(fade_wr),
      .rd     (rd),
      .rd_data(rd_data)
  );

  fade_scanout #(
      .H_ACTIVE(H_ACTIVE),
      .V_ACTIVE(V_ACTIVE)
  ) i_fade_scanout (
      .clk     (clk),
      .rst     (rst),
      .scan    (scan),
      .fade_now(fade_now),
      .rd      (rd),
      .rd_data (rd_data),
      .fade_wr (fade_wr),
      .vga     (vga)
  );

  apb_ctrl i_apb_ctrl (
      .clk        (clk),
      .rst        (rst),
      .paddr      (paddr),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .frame_start(frame_start),
      .plot_en    (plot_en),
      .fade_now   (fade_now)
  );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);
  initial begin
    clk = 1'b0;
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

/* sim/tb_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_checker
  import fade_stripe_pkg::*;
#(
    parameter int H_ACTIVE = 16,
    parameter int H_FRONT  = 2,
    parameter int H_SYNC   = 2,
    parameter int H_BACK   = 2,
    parameter int V_ACTIVE = 8,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 1,
    parameter int V_BACK   = 1
) (
    input  logic        clk,
    input  logic        rst,
    input  adc_sample_t sample,
    input  logic        adc_valid,
    input  apb_addr_t   paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_data_t   pwdata,
    input  vga_t        vga,
    output logic        blank,
    output logic        synced,
    output int          frames,
    output int          errors
);
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int HS_START = H_ACTIVE + H_FRONT;
  localparam int VS_START = V_ACTIVE + V_FRONT;
  localparam int X_SHIFT  = ADC_DATA_BITS - $clog2(H_ACTIVE);
  localparam int Y_SHIFT  = ADC_DATA_BITS - $clog2(V_ACTIVE);

  pixel_t model [H_ACTIVE*V_ACTIVE];
  logic   plot_en_m;
  logic   fade_en_m;
  logic   fade_cur;
  int     period_m;
  int     div_m;
  int     h;
  int     v;
  int     hn;
  int     vn;
  int     xs;
  int     ys;
  logic   vs_q;
  pixel_t exp_pix;
  pixel_t act_pix;
  logic   exp_hs;
  logic   exp_vs;
  int     tests;
  int     failed_tests;
  int     errors_at_start;
  string  test_name;

  initial begin
    foreach (model[i]) model[i] = '0;
    plot_en_m = 1'b0;
    fade_en_m = 1'b0;
    fade_cur = 1'b0;
    period_m = 0;
    div_m = 0;
    h = 0;
    v = 0;
    vs_q = 1'b1;
    blank = 1'b0;
    synced = 1'b0;
    frames = 0;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    errors_at_start = 0;
    test_name = "none";
  end

  function automatic pixel_t gate_pixel(logic r, logic g, logic b);
    return {{COLOR_BITS{r}}, {COLOR_BITS{g}}, {COLOR_BITS{b}}};
  endfunction

  // each channel one step down, never below 0
  function automatic pixel_t one_step_dimmer(pixel_t p);
    pixel_t q;
    int c;
    for (c = 0; c < 3; c++) begin
      q[c*COLOR_BITS +: COLOR_BITS] =
          (p[c*COLOR_BITS +: COLOR_BITS] == 0) ? 0 : p[c*COLOR_BITS +: COLOR_BITS] - 1;
    end
    return q;
  endfunction

  task automatic compare(string what, int expv, int actv);
    if (expv != actv) begin
      errors++;
      $display("[ERROR] %s %s expected %0h actual %0h", test_name, what, expv, actv);
    end
  endtask

  task automatic start_test(string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors > errors_at_start) failed_tests++;
    $display("test %s: %s, %0d errors", test_name,
             (errors > errors_at_start) ? "fail" : "ok", errors - errors_at_start);
  endtask

  task automatic report();
    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
  endtask

  // register and plot snooping on the rising edge
  always @(posedge clk) begin
    if (rst) begin
      plot_en_m <= 1'b0;
      fade_en_m <= 1'b0;
      period_m  <= 0;
    end else begin
      if (psel && penable && pwrite) begin
        if (paddr == REG_CTRL) begin
          plot_en_m <= pwdata[CTRL_PLOT_EN];
          fade_en_m <= pwdata[CTRL_FADE_EN];
        end
        if (paddr == REG_FADE_PERIOD) period_m <= int'(pwdata[15:0]);
      end
      if (adc_valid && plot_en_m) begin
        xs = int'(sample.x) >> X_SHIFT;
        ys = int'(sample.y) >> Y_SHIFT;
        if (xs < H_ACTIVE && ys < V_ACTIVE) begin
          model[ys*H_ACTIVE+xs] <= gate_pixel(sample.red, sample.grn, sample.blu);
        end
      end
    end
  end

  // vga outputs are sampled mid-cycle
  always @(negedge clk) begin
    vs_q <= vga.vsync;
    if (!synced) begin
      if (!rst && vs_q && !vga.vsync) begin
        synced <= 1'b1;
        h <= 1;
        v <= VS_START;
      end
    end else begin
      exp_pix = (h < H_ACTIVE && v < V_ACTIVE) ? model[v*H_ACTIVE+h] : '0;
      act_pix = {vga.red, vga.grn, vga.blu};
      exp_hs = !(h >= HS_START && h < HS_START + H_SYNC);
      exp_vs = !(v >= VS_START && v < VS_START + V_SYNC);
      if (exp_pix != act_pix) begin
        errors++;
        $display("[ERROR] %s pixel (%0d,%0d) expected %0h actual %0h",
                 test_name, h, v, exp_pix, act_pix);
      end
      if (exp_hs != vga.hsync || exp_vs != vga.vsync) begin
        errors++;
        $display("[ERROR] %s syncs at (%0d,%0d) expected %b%b actual %b%b",
                 test_name, h, v, exp_hs, exp_vs, vga.hsync, vga.vsync);
      end
      if (h == 0 && v == 0) begin
        frames   <= frames + 1;
        fade_cur <= fade_en_m && (div_m == period_m);
        div_m    <= (div_m == period_m) ? 0 : (div_m + 1) % 65536;
      end
      if (fade_cur && h == H_ACTIVE - 1 && v == V_ACTIVE - 1) begin
        foreach (model[i]) model[i] <= one_step_dimmer(model[i]);
      end
      hn = (h == H_TOTAL - 1) ? 0 : h + 1;
      vn = (h == H_TOTAL - 1) ? ((v == V_TOTAL - 1) ? 0 : v + 1) : v;
      h <= hn;
      v <= vn;
      // stay clear of the frame turnover
      blank <= vn >= V_ACTIVE && !(vn == V_TOTAL - 1 && hn >= H_ACTIVE);
    end
  end

endmodule

`default_nettype wire

/* sim/tb_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_top
  import fade_stripe_pkg::*;
();
  localparam int H_ACTIVE = 16;
  localparam int H_FRONT  = 2;
  localparam int H_SYNC   = 2;
  localparam int H_BACK   = 2;
  localparam int V_ACTIVE = 8;
  localparam int V_FRONT  = 1;
  localparam int V_SYNC   = 1;
  localparam int V_BACK   = 1;
  localparam int PERIOD_NS = 100;
  localparam int FRAME_CYCLES = (H_ACTIVE + H_FRONT + H_SYNC + H_BACK) *
                                (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
  localparam int NUM_FRAMES = 70;
  localparam int LIMIT_NS = NUM_FRAMES * FRAME_CYCLES * PERIOD_NS + 50000;

  logic        clk;
  logic        rst;
  adc_sample_t sample;
  logic        adc_valid;
  apb_addr_t   paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;
  vga_t        vga;
  logic        blank;
  logic        synced;
  int          frames;
  int          errors;
  apb_data_t   rnd;

  tb_clock #(.PERIOD_NS(PERIOD_NS)) i_tb_clock (.clk(clk));

  adc_xy_vga_fade_stripe #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
      .NUM_S(4)
  ) i_adc_xy_vga_fade_stripe (
      .clk(clk), .rst(rst), .sample(sample), .adc_valid(adc_valid),
      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .vga(vga)
  );

  tb_checker #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) i_tb_checker (
      .clk(clk), .rst(rst), .sample(sample), .adc_valid(adc_valid),
      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
      .pwdata(pwdata), .vga(vga), .blank(blank), .synced(synced),
      .frames(frames), .errors(errors)
  );

  // bus and sample traffic only in vertical blanking once the checker is locked
  task automatic wait_blank();
    @(negedge clk);
    while (synced && !blank) @(negedge clk);
  endtask

  task automatic wait_frames(int n);
    int target;
    target = frames + n;
    while (frames < target) @(negedge clk);
  endtask

  task automatic apb_write(apb_addr_t a, apb_data_t d);
    wait_blank();
    paddr = a;
    pwdata = d;
    pwrite = 1'b1;
    psel = 1'b1;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  // setup starts right away, the caller picks the moment
  task automatic read_access(string name, apb_addr_t a, apb_data_t expv, logic exp_err);
    paddr = a;
    pwrite = 1'b0;
    psel = 1'b1;
    @(negedge clk);
    penable = 1'b1;
    i_tb_checker.compare({name, " prdata"}, int'(expv), int'(prdata));
    i_tb_checker.compare({name, " pslverr"}, int'(exp_err), int'(pslverr));
    i_tb_checker.compare({name, " pready"}, 1, int'(pready));
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_read(string name, apb_addr_t a, apb_data_t expv, logic exp_err);
    wait_blank();
    read_access(name, a, expv, exp_err);
  endtask

  task automatic send_samples(int n);
    repeat (n) begin
      wait_blank();
      sample.x = adc_t'($urandom);
      sample.y = adc_t'($urandom);
      sample.red = 1'($urandom);
      sample.grn = 1'($urandom);
      sample.blu = 1'($urandom);
      adc_valid = 1'b1;
      @(negedge clk);
      adc_valid = 1'b0;
    end
  endtask

  initial begin
    #(LIMIT_NS);
    $display("watchdog expired before the tests finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(29772));
    rst = 1'b1;
    sample = '0;
    adc_valid = 1'b0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    i_tb_checker.start_test("reset");
    @(negedge clk);
    i_tb_checker.compare("hsync", 1, int'(vga.hsync));
    i_tb_checker.compare("vsync", 1, int'(vga.vsync));
    i_tb_checker.compare("colour", 0, int'({vga.red, vga.grn, vga.blu}));
    check_read("ctrl", REG_CTRL, 0, 1'b0);
    check_read("period", REG_FADE_PERIOD, 0, 1'b0);
    while (!synced) @(negedge clk);
    wait_frames(2);
    i_tb_checker.end_test();

    i_tb_checker.start_test("sync");
    wait_frames(2);
    i_tb_checker.end_test();

    i_tb_checker.start_test("plot");
    apb_write(REG_CTRL, 32'h1);
    repeat (4) begin
      send_samples(6);
      wait_frames(1);
    end
    apb_write(REG_CTRL, 32'h0);
    send_samples(6);
    wait_frames(2);
    i_tb_checker.end_test();

    i_tb_checker.start_test("fade");
    apb_write(REG_CTRL, 32'h1);
    send_samples(8);
    apb_write(REG_FADE_PERIOD, $urandom % 3);
    apb_write(REG_CTRL, 32'h2);
    // long enough for full-scale pixels to reach 0 at any period used here
    wait_frames(24);
    apb_write(REG_CTRL, 32'h1);
    send_samples(6);
    apb_write(REG_CTRL, 32'h0);
    wait_frames(3);
    i_tb_checker.end_test();

    i_tb_checker.start_test("apb");
    repeat (6) begin
      rnd = $urandom & 32'h3;
      apb_write(REG_CTRL, rnd);
      check_read("ctrl", REG_CTRL, rnd, 1'b0);
      rnd = $urandom;
      apb_write(REG_FADE_PERIOD, rnd);
      check_read("period", REG_FADE_PERIOD, rnd & 32'hffff, 1'b0);
    end
    check_read("unknown", 8'h10, 0, 1'b1);
    wait_blank();
    read_access("frame count", REG_FRAME_COUNT, apb_data_t'((frames + 1) % 65536), 1'b0);
    apb_write(REG_CTRL, 32'h0);
    i_tb_checker.end_test();

    i_tb_checker.report();
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
design/fade_stripe_pkg.sv
design/vga_timing.sv
design/adc_plot.sv
design/stripe_framebuffer.sv
design/fade_scanout.sv
design/apb_ctrl.sv
design/adc_xy_vga_fade_stripe.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_top -f files.f \
  -o tb_top_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_top_sim > sim.log 2>&1 \
  || { echo "simulation exited with an error, see sim.log"; exit 1; }

grep -q "\*\*\* TEST PASSED \*\*\*" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
